//--- all.f
verilog/dram_pkg.sv
verilog/dram_cfg_regs.sv
verilog/dram_admit.sv
verilog/dram_burst_seq.sv
verilog/dram_mem_array.sv
verilog/dram_rd_pipe.sv
verilog/dram_sim_top.sv
dv/tb_dram_sim.sv

//--- Bender.yml
package:
  name: dram_sim

sources:
  - verilog/dram_pkg.sv
  - verilog/dram_cfg_regs.sv
  - verilog/dram_admit.sv
  - verilog/dram_burst_seq.sv
  - verilog/dram_mem_array.sv
  - verilog/dram_rd_pipe.sv
  - verilog/dram_sim_top.sv
  - target: simulation
    files:
      - dv/tb_dram_sim.sv

//--- dv/tb_dram_sim.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dram_sim import dram_pkg::*; ();

  localparam int DEPTH      = 64;
  localparam int LATENCY    = 16;
  localparam int WORDS      = 2 * DEPTH;
  localparam int IDX_W      = $clog2(WORDS);
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int N_RAND     = 24;
  localparam int N_B2B      = 8;
  localparam int FLOOD_LEN  = 180;
  localparam int HARD_LEN   = 60;
  localparam int DRAIN_MAX  = 120;  // Worst case for one drain
  localparam int RUN_CYCLES = RST_CYCLES + 3 * DEPTH + 6 * N_RAND + 2 * N_B2B
                            + FLOOD_LEN + HARD_LEN + 5 * DRAIN_MAX + 40;
  localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] due;  // Cycle in which rd_valid is expected
    dram_word_t  word;
  } rd_exp_s;

  logic        dram_clk = 1'b0;
  logic        dram_rst;
  dram_cmd_s   cmd;
  logic        cmd_valid;
  dram_wdata_s wdata;
  dram_word_t  rd_data;
  logic        rd_valid;
  logic        ready;
  logic        cfg_wr;
  cfg_addr_t   cfg_addr;
  cfg_data_t   cfg_wdata;
  cfg_data_t   cfg_rdata;

  // Reference model state
  dram_word_t       shadow [WORDS];
  rd_exp_s          exp_q [$];
  logic [31:0]      cyc;
  dram_occ_t        occ_m;
  logic             busy_m;
  logic [IDX_W-1:0] beat1_idx;
  logic             rnw_m;
  logic             hard_m;
  dram_occ_t        wait_m;
  dram_occ_t        over_m;
  cfg_data_t        acc_tally;
  cfg_data_t        ref_tally;
  logic             exp_rd_valid;
  dram_word_t       exp_rd_data;
  logic             cfg_chk;
  cfg_data_t        exp_cfg_rdata;
  logic [31:0]      lfsr;

  always #(CLK_PERIOD / 2) dram_clk = ~dram_clk;

  dram_sim_top #(
    .DRAM_DEPTH (DEPTH),
    .RD_LATENCY (LATENCY)
  ) dut0 (
    .dram_clk  (dram_clk),
    .dram_rst  (dram_rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .wdata     (wdata),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .ready     (ready),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  task automatic stop_with_error(string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // Checks, sampled at the rising edge
  // ------------------------------------------------------------
  a_ready: assert property (@(posedge dram_clk) disable iff (dram_rst)
      ready == (occ_m < wait_m))
    else stop_with_error($sformatf("CHECK FAILED at %0t: ready is %0b at occupancy %0d",
                                   $time, $sampled(ready), $sampled(occ_m)));

  a_rd_valid: assert property (@(posedge dram_clk) disable iff (dram_rst)
      rd_valid == exp_rd_valid)
    else stop_with_error($sformatf("CHECK FAILED at %0t: rd_valid is %0b, expected %0b",
                                   $time, $sampled(rd_valid), $sampled(exp_rd_valid)));

  a_rd_data: assert property (@(posedge dram_clk) disable iff (dram_rst)
      !rd_valid || rd_data == exp_rd_data)
    else stop_with_error($sformatf("CHECK FAILED at %0t: rd_data %h, expected %h",
                                   $time, $sampled(rd_data), $sampled(exp_rd_data)));

  a_cfg_rdata: assert property (@(posedge dram_clk) disable iff (dram_rst)
      !cfg_chk || cfg_rdata == exp_cfg_rdata)
    else stop_with_error($sformatf("CHECK FAILED at %0t: cfg reg %0d reads %0d, expected %0d",
                                   $time, $sampled(cfg_addr), $sampled(cfg_rdata),
                                   $sampled(exp_cfg_rdata)));

  // ------------------------------------------------------------
  // Random source and reference helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'hA300_0000;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [143:0] take_bits(int n);
    logic [143:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic dram_wdata_s rand_wdata();
    dram_wdata_s wd;
    wd.data = dram_word_t'(take_bits(144));
    wd.be   = dram_be_t'(take_bits(18));
    return wd;
  endfunction

  // Burst number times two plus the beat, wrapped to the array
  function automatic logic [IDX_W-1:0] word_index(dram_addr_t addr, logic [31:0] beat_no);
    return IDX_W'(((addr >> 2) * 2 + beat_no) % 32'(WORDS));
  endfunction

  function automatic dram_word_t merge_bytes(dram_word_t old, dram_wdata_s wd);
    dram_word_t r;
    r = old;
    for (int b = 0; b < $bits(dram_be_t); b++) begin
      if (wd.be[b]) begin
        r[8*b +: 8] = wd.data[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic do_beat(logic [IDX_W-1:0] idx, logic rnw);
    rd_exp_s e;
    if (rnw) begin
      e.due  = cyc + 32'(LATENCY);
      e.word = shadow[idx];
      exp_q.push_back(e);
    end else begin
      shadow[idx] = merge_bytes(shadow[idx], wdata);
    end
  endtask

  // Advance one cycle and update the model from what was driven in it
  task automatic tick();
    logic blocked;
    logic acc;
    @(posedge dram_clk);
    blocked = busy_m || (hard_m ? !(occ_m < wait_m) : (occ_m >= over_m));
    acc     = cmd_valid && !blocked;
    if (cmd_valid && blocked) begin
      ref_tally++;
    end
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      void'(exp_q.pop_front());
    end
    if (busy_m) begin
      do_beat(beat1_idx, rnw_m);  // Second beat
    end else if (acc) begin
      acc_tally++;
      do_beat(word_index(cmd.addr, 32'd0), cmd.rnw);
      beat1_idx = word_index(cmd.addr, 32'd1);
      rnw_m     = cmd.rnw;
    end
    if (acc) begin
      occ_m++;
    end else if (!busy_m && occ_m != 0) begin
      occ_m--;
    end
    busy_m = acc;
    if (cfg_wr) begin
      case (cfg_addr)
        CFG_MODE:        hard_m = cfg_wdata[0];
        CFG_WAIT_THRESH: wait_m = dram_occ_t'(cfg_wdata);
        CFG_OVER_THRESH: over_m = dram_occ_t'(cfg_wdata);
        default: ;
      endcase
    end
    cyc++;
    exp_rd_valid = exp_q.size() != 0 && exp_q[0].due == cyc;
    if (exp_rd_valid) begin
      exp_rd_data = exp_q[0].word;
    end
    @(negedge dram_clk);
  endtask

  // ------------------------------------------------------------
  // Stimulus, always driven after the falling edge
  // ------------------------------------------------------------
  task automatic idle(int n);
    cmd_valid = 1'b0;
    repeat (n) tick();
  endtask

  task automatic run_burst(logic rnw, dram_addr_t addr, dram_wdata_s wd0, dram_wdata_s wd1);
    cmd_valid = 1'b1;
    cmd.addr  = addr;
    cmd.rnw   = rnw;
    wdata     = wd0;
    tick();
    cmd_valid = 1'b0;
    wdata     = wd1;  // Beat 1 takes the data of its own cycle
    tick();
  endtask

  task automatic write_cfg(cfg_addr_t a, cfg_data_t d);
    cfg_wr    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    tick();
    cfg_wr = 1'b0;
  endtask

  task automatic expect_cfg(cfg_addr_t a, cfg_data_t d);
    cfg_addr      = a;
    exp_cfg_rdata = d;
    cfg_chk       = 1'b1;
    tick();
    cfg_chk = 1'b0;
  endtask

  task automatic drain();
    idle(1);
    while (occ_m != 0 || busy_m || exp_q.size() != 0) begin
      tick();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_error("Timeout: the tests did not finish within their cycle budget");
  end

  initial begin
    dram_addr_t  addrs [N_RAND];
    dram_addr_t  addr_b;
    dram_wdata_s wd0;
    dram_wdata_s wd1;
    $timeformat(-9, 0, " ns", 0);
    lfsr      = 32'h95ef_fa48;
    dram_rst  = 1'b1;
    cmd       = '0;
    cmd_valid = 1'b0;
    wdata     = '0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    cfg_chk       = 1'b0;
    exp_cfg_rdata = '0;
    exp_rd_valid  = 1'b0;
    exp_rd_data   = '0;
    cyc       = '0;
    occ_m     = '0;
    busy_m    = 1'b0;
    beat1_idx = '0;
    rnw_m     = 1'b0;
    hard_m    = 1'b0;
    wait_m    = DEF_WAIT_THRESH;
    over_m    = DEF_OVER_THRESH;
    acc_tally = '0;
    ref_tally = '0;
    repeat (RST_CYCLES) @(negedge dram_clk);
    dram_rst = 1'b0;

    // Fill every word, one idle cycle per burst keeps occupancy near zero
    for (int b = 0; b < DEPTH; b++) begin
      wd0    = rand_wdata();
      wd1    = rand_wdata();
      wd0.be = '1;
      wd1.be = '1;
      run_burst(1'b0, dram_addr_t'(4 * b), wd0, wd1);
      idle(1);
    end

    // Random partial writes, then read them back
    for (int i = 0; i < N_RAND; i++) begin
      addrs[i] = dram_addr_t'(take_bits(32));
      run_burst(1'b0, addrs[i], rand_wdata(), rand_wdata());
      idle(1);
    end
    for (int i = 0; i < N_RAND; i++) begin
      run_burst(1'b1, addrs[i], '0, '0);
      idle(1);
    end
    drain();

    // Back to back reads with several in flight
    for (int i = 0; i < N_B2B; i++) begin
      run_burst(1'b1, dram_addr_t'(take_bits(32)), '0, '0);
    end
    drain();

    // Write presented during beat 1 of a read is dropped
    expect_cfg(CFG_REFUSE_CNT, ref_tally);
    addr_b    = dram_addr_t'(take_bits(32));
    cmd_valid = 1'b1;
    cmd.addr  = dram_addr_t'(take_bits(32));
    cmd.rnw   = 1'b1;
    tick();
    cmd.addr  = addr_b;
    cmd.rnw   = 1'b0;
    wdata     = rand_wdata();
    wdata.be  = '1;
    tick();
    drain();
    expect_cfg(CFG_REFUSE_CNT, ref_tally);
    run_burst(1'b1, addr_b, '0, '0);
    drain();

    // Soft mode flood, occupancy climbs to the overflow level
    cmd_valid = 1'b1;
    for (int i = 0; i < FLOOD_LEN; i++) begin
      cmd.addr = dram_addr_t'(take_bits(32));
      cmd.rnw  = 1'b1;
      tick();
    end
    drain();
    expect_cfg(CFG_ACCEPT_CNT, acc_tally);
    expect_cfg(CFG_REFUSE_CNT, ref_tally);

    // Hard mode with small thresholds
    write_cfg(CFG_MODE, 32'd1);
    write_cfg(CFG_WAIT_THRESH, 32'd6);
    write_cfg(CFG_OVER_THRESH, 32'd8);
    expect_cfg(CFG_MODE, 32'd1);
    expect_cfg(CFG_WAIT_THRESH, 32'd6);
    expect_cfg(CFG_OVER_THRESH, 32'd8);
    cmd_valid = 1'b1;
    for (int i = 0; i < HARD_LEN; i++) begin
      cmd.addr = dram_addr_t'(take_bits(32));
      cmd.rnw  = 1'(take_bits(1));
      wdata    = rand_wdata();
      tick();
    end
    drain();
    expect_cfg(CFG_ACCEPT_CNT, acc_tally);
    expect_cfg(CFG_REFUSE_CNT, ref_tally);

    idle(4);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/dram_sim_top.sv
`timescale 1ns/10ps
`default_nettype none

module dram_sim_top import dram_pkg::*; #(
  parameter int DRAM_DEPTH = 1024,  // Bursts
  parameter int RD_LATENCY = 16     // Cycles, at least 2
) (
  input  logic        dram_clk,
  input  logic        dram_rst,

  // Command port
  input  dram_cmd_s   cmd,
  input  logic        cmd_valid,
  input  dram_wdata_s wdata,

  // Read return
  output dram_word_t  rd_data,
  output logic        rd_valid,
  output logic        ready,

  // Configuration bus
  input  logic        cfg_wr,
  input  cfg_addr_t   cfg_addr,
  input  cfg_data_t   cfg_wdata,
  output cfg_data_t   cfg_rdata
);

  logic       accept;
  logic       refuse;
  logic       busy;
  dram_cfg_s  cfg;
  dram_beat_s beat;
  logic       beat_en;
  dram_word_t rd_word;
  logic       rd_in_valid;

  // ----------------------------------------------------------
  // Control path
  // ----------------------------------------------------------
  dram_cfg_regs u_cfg_regs (
    .dram_clk  (dram_clk),
    .dram_rst  (dram_rst),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .accept    (accept),
    .refuse    (refuse),
    .cfg       (cfg)
  );

  dram_admit u_admit (
    .dram_clk  (dram_clk),
    .dram_rst  (dram_rst),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .cfg       (cfg),
    .accept    (accept),
    .refuse    (refuse),
    .ready     (ready)
  );

  dram_burst_seq u_burst_seq (
    .dram_clk (dram_clk),
    .dram_rst (dram_rst),
    .accept   (accept),
    .cmd      (cmd),
    .wdata    (wdata),
    .busy     (busy),
    .beat     (beat),
    .beat_en  (beat_en)
  );

  // ----------------------------------------------------------
  // Data path
  // ----------------------------------------------------------
  dram_mem_array #(
    .DRAM_DEPTH (DRAM_DEPTH)
  ) u_mem_array (
    .dram_clk (dram_clk),
    .beat     (beat),
    .beat_en  (beat_en),
    .rd_word  (rd_word)
  );

  assign rd_in_valid = beat_en & beat.rnw;  // Only read beats return data

  dram_rd_pipe #(
    .RD_LATENCY (RD_LATENCY)
  ) u_rd_pipe (
    .dram_clk (dram_clk),
    .dram_rst (dram_rst),
    .in_valid (rd_in_valid),
    .in_data  (rd_word),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

//--- verilog/dram_rd_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module dram_rd_pipe import dram_pkg::*; #(
  parameter int RD_LATENCY = 16  // At least 2
) (
  input  logic       dram_clk,
  input  logic       dram_rst,
  input  logic       in_valid,
  input  dram_word_t in_data,
  output logic       rd_valid,
  output dram_word_t rd_data
);

  logic [RD_LATENCY-1:0] vld_sr;
  dram_word_t            data_sr [RD_LATENCY];

  // ----------------------------------------------------------
  // Valid line
  // ----------------------------------------------------------
  always_ff @(posedge dram_clk) begin
    if (dram_rst) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[RD_LATENCY-2:0], in_valid};
    end
  end

  // Data shifts every cycle, valid or not
  always_ff @(posedge dram_clk) begin
    data_sr[0] <= in_data;
    for (int i = 1; i < RD_LATENCY; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  assign rd_valid = vld_sr[RD_LATENCY-1];
  assign rd_data  = data_sr[RD_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/dram_mem_array.sv
`timescale 1ns/10ps
`default_nettype none

module dram_mem_array import dram_pkg::*; #(
  parameter int DRAM_DEPTH = 1024
) (
  input  logic       dram_clk,
  input  dram_beat_s beat,
  input  logic       beat_en,
  output dram_word_t rd_word
);

  // Two words per burst
  localparam int WORDS = 2 * DRAM_DEPTH;
  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam int BYTES = $bits(dram_be_t);

  dram_word_t mem [WORDS];  // Contents survive reset

  dram_word_addr_t       idx_full;
  logic [IDX_W-1:0]      idx;

  // ----------------------------------------------------------
  // Addressing
  // ----------------------------------------------------------
  // Word addresses beyond the array wrap around
  assign idx_full = beat.word_addr % dram_word_addr_t'(WORDS);
  assign idx      = idx_full[IDX_W-1:0];

  // ----------------------------------------------------------
  // Byte-enabled write
  // ----------------------------------------------------------
  always_ff @(posedge dram_clk) begin
    if (beat_en && !beat.rnw) begin
      for (int b = 0; b < BYTES; b++) begin
        if (beat.wdata.be[b]) begin
          mem[idx][8*b +: 8] <= beat.wdata.data[8*b +: 8];
        end
      end
    end
  end

  // Read is combinational, the read pipe registers it
  assign rd_word = mem[idx];

endmodule

`default_nettype wire

//--- verilog/dram_burst_seq.sv
`timescale 1ns/10ps
`default_nettype none

module dram_burst_seq import dram_pkg::*; (
  input  logic        dram_clk,
  input  logic        dram_rst,
  input  logic        accept,
  input  dram_cmd_s   cmd,
  input  dram_wdata_s wdata,
  output logic        busy,
  output dram_beat_s  beat,
  output logic        beat_en
);

  seq_state_e      state_q;
  dram_word_addr_t beat0_waddr;
  dram_word_addr_t beat1_waddr_q;
  logic            rnw_q;

  // ----------------------------------------------------------
  // Word addressing
  // ----------------------------------------------------------
  // Drop the low two byte address bits, then make room for the beat index
  assign beat0_waddr = {1'b0, cmd.addr[31:2], 1'b0};

  // Burst context, kept for the second beat only
  always_ff @(posedge dram_clk) begin
    if (accept) begin
      beat1_waddr_q <= beat0_waddr + 1'b1;
      rnw_q         <= cmd.rnw;
    end
  end

  // ----------------------------------------------------------
  // Beat FSM
  // ----------------------------------------------------------
  always_ff @(posedge dram_clk) begin
    if (dram_rst) begin
      state_q <= SEQ_BEAT0;
    end else begin
      case (state_q)
        SEQ_BEAT0: begin
          if (accept) begin
            state_q <= SEQ_BEAT1;
          end
        end
        SEQ_BEAT1: state_q <= SEQ_BEAT0;  // Second beat always follows
        default:   state_q <= SEQ_BEAT0;
      endcase
    end
  end

  assign busy = state_q == SEQ_BEAT1;

  // Beat 0 passes straight through from the command port
  always_comb begin
    beat.wdata = wdata;  // Each beat takes the data of its own cycle
    if (state_q == SEQ_BEAT1) begin
      beat.word_addr = beat1_waddr_q;
      beat.rnw       = rnw_q;
      beat_en        = 1'b1;
    end else begin
      beat.word_addr = beat0_waddr;
      beat.rnw       = cmd.rnw;
      beat_en        = accept;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dram_admit.sv
`timescale 1ns/10ps
`default_nettype none

module dram_admit import dram_pkg::*; (
  input  logic      dram_clk,
  input  logic      dram_rst,
  input  logic      cmd_valid,
  input  logic      busy,
  input  dram_cfg_s cfg,
  output logic      accept,
  output logic      refuse,
  output logic      ready
);

  dram_occ_t occ_q;
  logic      overflow;
  logic      blocked;

  // ----------------------------------------------------------
  // Levels from the occupancy count
  // ----------------------------------------------------------
  assign ready    = occ_q < cfg.wait_thresh;
  assign overflow = occ_q >= cfg.over_thresh;

  // Hard mode honours ready, soft mode only the overflow level.
  // Nothing gets in while beat 1 of a burst is running
  assign blocked = busy | (cfg.hard_ready ? !ready : overflow);

  assign accept = cmd_valid & !blocked;
  assign refuse = cmd_valid & blocked;

  // Occupancy drains by one on each idle cycle
  always_ff @(posedge dram_clk) begin
    if (dram_rst) begin
      occ_q <= '0;
    end else if (accept) begin
      occ_q <= occ_q + 1'b1;
    end else if (!busy && occ_q != '0) begin
      occ_q <= occ_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dram_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module dram_cfg_regs import dram_pkg::*; (
  input  logic      dram_clk,
  input  logic      dram_rst,
  input  logic      cfg_wr,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output cfg_data_t cfg_rdata,
  input  logic      accept,
  input  logic      refuse,
  output dram_cfg_s cfg
);

  dram_cfg_s cfg_q;
  cfg_data_t accept_cnt_q;
  cfg_data_t refuse_cnt_q;

  // ----------------------------------------------------------
  // Writable mode and thresholds
  // ----------------------------------------------------------
  always_ff @(posedge dram_clk) begin
    if (dram_rst) begin
      cfg_q.hard_ready  <= 1'b0;             // Soft mode out of reset
      cfg_q.wait_thresh <= DEF_WAIT_THRESH;
      cfg_q.over_thresh <= DEF_OVER_THRESH;
    end else if (cfg_wr) begin
      case (cfg_addr)
        CFG_MODE:        cfg_q.hard_ready  <= cfg_wdata[0];
        CFG_WAIT_THRESH: cfg_q.wait_thresh <= cfg_wdata[$bits(dram_occ_t)-1:0];
        CFG_OVER_THRESH: cfg_q.over_thresh <= cfg_wdata[$bits(dram_occ_t)-1:0];
        default: ;  // Counters are read only
      endcase
    end
  end

  assign cfg = cfg_q;

  // ----------------------------------------------------------
  // Statistics, saturating at all ones
  // ----------------------------------------------------------
  always_ff @(posedge dram_clk) begin
    if (dram_rst) begin
      accept_cnt_q <= '0;
      refuse_cnt_q <= '0;
    end else begin
      if (accept && accept_cnt_q != '1) begin
        accept_cnt_q <= accept_cnt_q + 1'b1;
      end
      if (refuse && refuse_cnt_q != '1) begin
        refuse_cnt_q <= refuse_cnt_q + 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    case (cfg_addr)
      CFG_MODE:        cfg_rdata = cfg_data_t'(cfg_q.hard_ready);
      CFG_WAIT_THRESH: cfg_rdata = cfg_data_t'(cfg_q.wait_thresh);
      CFG_OVER_THRESH: cfg_rdata = cfg_data_t'(cfg_q.over_thresh);
      CFG_ACCEPT_CNT:  cfg_rdata = accept_cnt_q;
      CFG_REFUSE_CNT:  cfg_rdata = refuse_cnt_q;
      default:         cfg_rdata = '0;  // Unmapped
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/dram_pkg.sv
`default_nettype none

package dram_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  typedef logic [31:0]  dram_addr_t;       // Byte address from the command port
  typedef logic [31:0]  dram_word_addr_t;  // Word address, two words per burst
  typedef logic [143:0] dram_word_t;       // 18 bytes
  typedef logic [17:0]  dram_be_t;         // One enable per byte
  typedef logic [7:0]   dram_occ_t;        // Occupancy count and thresholds
  typedef logic [2:0]   cfg_addr_t;
  typedef logic [31:0]  cfg_data_t;

  // ----------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------
  typedef struct packed {
    dram_addr_t addr;
    logic       rnw;    // High for read
  } dram_cmd_s;

  typedef struct packed {
    dram_word_t data;
    dram_be_t   be;
  } dram_wdata_s;

  // One memory operation, a burst is two of these
  typedef struct packed {
    dram_word_addr_t word_addr;
    logic            rnw;
    dram_wdata_s     wdata;
  } dram_beat_s;

  typedef struct packed {
    logic      hard_ready;   // Refuse whenever ready is low
    dram_occ_t wait_thresh;  // ready while occ is below this
    dram_occ_t over_thresh;  // overflow from this occ upward
  } dram_cfg_s;

  typedef enum logic {
    SEQ_BEAT0,
    SEQ_BEAT1
  } seq_state_e;

  // Configuration register map
  localparam cfg_addr_t CFG_MODE        = 3'd0;
  localparam cfg_addr_t CFG_WAIT_THRESH = 3'd1;
  localparam cfg_addr_t CFG_OVER_THRESH = 3'd2;
  localparam cfg_addr_t CFG_ACCEPT_CNT  = 3'd3;
  localparam cfg_addr_t CFG_REFUSE_CNT  = 3'd4;

  localparam dram_occ_t DEF_WAIT_THRESH = 8'd64;
  localparam dram_occ_t DEF_OVER_THRESH = 8'd72;

endpackage

`default_nettype wire
